// ==== Bender.yml ====
package:
  name: rv_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_mem_pkg.sv
      - hdl/rv_store_fmt.sv
      - hdl/rv_load_fmt.sv
      - hdl/rv_redirect_check.sv
      - hdl/rv_pipe_reg.sv
      - hdl/rv_stage_mem.sv
      - hdl/rv_dmem.sv
      - hdl/rv_mem_subsys.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/rv_mem_props.sv
      - verification/rv_mem_checker.sv
      - verification/rv_mem_tb.sv

// ==== flist.f ====
+incdir+hdl
hdl/rv_mem_pkg.sv
hdl/rv_store_fmt.sv
hdl/rv_load_fmt.sv
hdl/rv_redirect_check.sv
hdl/rv_pipe_reg.sv
hdl/rv_stage_mem.sv
hdl/rv_dmem.sv
hdl/rv_mem_subsys.sv
verification/rv_mem_props.sv
verification/rv_mem_checker.sv
verification/rv_mem_tb.sv

// ==== hdl/rv_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_dmem (
  input logic clk,
  input logic ren,
  input logic [`RV_XLEN-1:0] raddr,
  output logic [`RV_XLEN-1:0] rdata,
  input logic we,
  input logic [`RV_XLEN-1:0] waddr,
  input logic [`RV_XLEN-1:0] wdata,
  input logic [3:0] wstrb
);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] ridx;
  logic [`RV_DMEM_AW-1:0] widx;

  // Word index from address bits 2 and up
  assign ridx = raddr[`RV_DMEM_AW+1:2];
  assign widx = waddr[`RV_DMEM_AW+1:2];

  // Asynchronous read, zero when idle
  assign rdata = ren ? mem[ridx] : '0;

  // Byte-strobed write
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_load_fmt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_load_fmt import rv_mem_pkg::*; (
  input logic [`RV_XLEN-1:0] rdata,
  input logic [1:0] byte_off,
  input logic [2:0] funct3,
  output logic [`RV_XLEN-1:0] data
);

  logic [7:0] lane_b;
  logic [15:0] lane_h;

  // Byte lane named by the low address bits
  assign lane_b = rdata[{byte_off, 3'b000} +: 8];

  // Halfword lane, bit 0 is known clear for legal accesses
  assign lane_h = byte_off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      f3_byte: begin
        // Sign from bit 7 of the lane
        data = {{(`RV_XLEN - 8){lane_b[7]}}, lane_b};
      end
      f3_byte_u: begin
        data = {{(`RV_XLEN - 8){1'b0}}, lane_b};
      end
      f3_half: begin
        // Sign from bit 15 of the lane
        data = {{(`RV_XLEN - 16){lane_h[15]}}, lane_h};
      end
      f3_half_u: begin
        data = {{(`RV_XLEN - 16){1'b0}}, lane_h};
      end
      default: begin
        // Full word, no extension
        data = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_mem_defines.svh ====
`ifndef RV_MEM_DEFINES_SVH
`define RV_MEM_DEFINES_SVH

// Data path and address width of the core
`define RV_XLEN 32

// Data SRAM depth in 32-bit words
`define RV_DMEM_WORDS 256

// Word index bits into the data SRAM
// Must match the log2 of RV_DMEM_WORDS
`define RV_DMEM_AW 8

`endif

// ==== hdl/rv_mem_pkg.sv ====
`default_nettype none

`include "rv_mem_defines.svh"

package rv_mem_pkg;

  // JAL major opcode, used for return-stack push decode
  localparam logic [6:0] op_jal = 7'b1101111;
  // Canonical NOP (addi x0, x0, 0)
  localparam logic [31:0] op_nop = 32'h0000_0013;

  // Load and store width encodings
  localparam logic [2:0] f3_byte = 3'b000;
  localparam logic [2:0] f3_half = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // Result source of the instruction in MEM
  // The M-unit slot carries the load data here
  typedef enum logic [2:0] {
    res_alu = 3'd0,
    res_mem = 3'd1,
    res_pc4 = 3'd2,
    res_tgt = 3'd3
  } res_sel_t;

  typedef enum logic [1:0] {
    trap_none = 2'd0,
    trap_ecall = 2'd1,
    trap_ill = 2'd2,
    trap_ldst_misalign = 2'd3
  } trap_code_t;

  // Everything the execute stage hands over
  typedef struct packed {
    logic valid;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    res_sel_t res_sel;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [31:0] instr;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] jb_target;
    logic trap;
    trap_code_t trap_code;
  } mem_in_t;

  // Branch outcome and prediction made at fetch
  typedef struct packed {
    logic is_branch;
    logic is_jalr;
    logic branch_taken;
    logic pred_taken;
    logic [`RV_XLEN-1:0] pred_target;
  } bp_in_t;

  // MEM/WB payload
  typedef struct packed {
    logic reg_write;
    res_sel_t res_sel;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] jb_target;
    logic [`RV_XLEN-1:0] load_data;
  } wb_out_t;

  typedef struct packed {
    logic mispredicted;
    logic jalr_mispredicted;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic push;
    logic [`RV_XLEN-1:0] push_addr;
    logic pop;
  } ras_upd_t;

endpackage

`default_nettype wire

// ==== hdl/rv_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

// Memory stage with its data SRAM
module rv_mem_subsys import rv_mem_pkg::*; (
  input logic clk,
  input logic rst_n,
  input mem_in_t mem_in,
  input bp_in_t bp_in,
  input logic stall,
  input logic op_active,
  output logic [`RV_XLEN-1:0] result_mem,
  output redirect_t redirect,
  output ras_upd_t ras_upd,
  output wb_out_t wb_out,
  output logic valid_wb,
  output logic trap_wb,
  output trap_code_t trap_code_wb
);

  // SRAM port between stage and memory
  logic dmem_ren;
  logic [`RV_XLEN-1:0] dmem_raddr;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic dmem_we;
  logic [`RV_XLEN-1:0] dmem_waddr;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic [3:0] dmem_wstrb;

  rv_stage_mem u_stage_mem (
    .clk(clk),
    .rst_n(rst_n),
    .mem_in(mem_in),
    .bp_in(bp_in),
    .stall(stall),
    .op_active(op_active),
    .dmem_ren(dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we(dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .result_mem(result_mem),
    .redirect(redirect),
    .ras_upd(ras_upd),
    .wb_out(wb_out),
    .valid_wb(valid_wb),
    .trap_wb(trap_wb),
    .trap_code_wb(trap_code_wb)
  );

  rv_dmem u_dmem (
    .clk(clk),
    .ren(dmem_ren),
    .raddr(dmem_raddr),
    .rdata(dmem_rdata),
    .we(dmem_we),
    .waddr(dmem_waddr),
    .wdata(dmem_wdata),
    .wstrb(dmem_wstrb)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// Generic stage register
// Payload type and reset value come in as parameters
module rv_pipe_reg #(
  parameter type payload_t = logic [31:0],
  parameter payload_t rst_val = '0
) (
  input logic clk,
  input logic rst_n,
  input logic stall,
  input payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q <= rst_val;
    end else if (!stall) begin
      // Advance only when downstream accepts
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_redirect_check.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_redirect_check import rv_mem_pkg::*; (
  input bp_in_t bp_in,
  input logic [`RV_XLEN-1:0] pc_plus4,
  input logic [`RV_XLEN-1:0] jb_target,
  input logic [31:0] instr,
  output redirect_t redirect,
  output ras_upd_t ras_upd
);

  logic branch_mispred;
  logic jalr_mispred;
  logic is_jal;
  logic [4:0] rd;

  // Branch outcome disagrees with the prediction
  assign branch_mispred = bp_in.is_branch && (bp_in.branch_taken != bp_in.pred_taken);

  // JALR needs both a taken prediction and the right target
  assign jalr_mispred = bp_in.is_jalr &&
                        (!bp_in.pred_taken || (bp_in.pred_target != jb_target));

  assign redirect.mispredicted = branch_mispred || jalr_mispred;
  assign redirect.jalr_mispredicted = jalr_mispred;

  // Predicted taken but fell through, so restart at the next PC
  assign redirect.target = (branch_mispred && !bp_in.branch_taken) ? pc_plus4 : jb_target;

  assign is_jal = (instr[6:0] == op_jal);
  assign rd = instr[11:7];

  // Calls push the return address, any JALR pops
  assign ras_upd.push = (is_jal || bp_in.is_jalr) && (rd != 5'd0);
  assign ras_upd.push_addr = pc_plus4;
  assign ras_upd.pop = bp_in.is_jalr;

endmodule

`default_nettype wire

// ==== hdl/rv_stage_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_stage_mem import rv_mem_pkg::*; (
  input logic clk,
  input logic rst_n,
  input mem_in_t mem_in,
  input bp_in_t bp_in,
  input logic stall,
  input logic op_active,
  output logic dmem_ren,
  output logic [`RV_XLEN-1:0] dmem_raddr,
  input logic [`RV_XLEN-1:0] dmem_rdata,
  output logic dmem_we,
  output logic [`RV_XLEN-1:0] dmem_waddr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0] dmem_wstrb,
  output logic [`RV_XLEN-1:0] result_mem,
  output redirect_t redirect,
  output ras_upd_t ras_upd,
  output wb_out_t wb_out,
  output logic valid_wb,
  output logic trap_wb,
  output trap_code_t trap_code_wb
);

  localparam wb_out_t wb_rst = '0;

  logic is_half;
  logic is_word;
  logic misalign;
  logic trap_any;
  trap_code_t trap_code_mem;
  logic st_en;
  logic [`RV_XLEN-1:0] load_data;
  wb_out_t wb_d;

  // Access size from funct3, signedness does not matter here
  assign is_half = (mem_in.funct3 == f3_half) || (mem_in.funct3 == f3_half_u);
  assign is_word = (mem_in.funct3 == f3_word);

  // Halfword needs bit 0 clear, word needs bits 1:0 clear
  assign misalign = (mem_in.mem_read || mem_in.mem_write) &&
                    ((is_half && mem_in.alu_result[0]) ||
                     (is_word && (mem_in.alu_result[1:0] != 2'b00)));

  // Execute trap or misalignment, the latter wins the code
  assign trap_any = mem_in.trap || misalign;
  assign trap_code_mem = misalign ? trap_ldst_misalign : mem_in.trap_code;

  // Memory port is quiet on any trap
  assign st_en = mem_in.mem_write && !trap_any;
  assign dmem_ren = mem_in.mem_read && !trap_any;
  assign dmem_we = st_en;
  // Word-aligned addresses, lanes picked by strobes
  assign dmem_raddr = {mem_in.alu_result[`RV_XLEN-1:2], 2'b00};
  assign dmem_waddr = {mem_in.alu_result[`RV_XLEN-1:2], 2'b00};

  rv_store_fmt u_store_fmt (
    .data(mem_in.rs2_data),
    .byte_off(mem_in.alu_result[1:0]),
    .funct3(mem_in.funct3),
    .mem_write(st_en),
    .wdata(dmem_wdata),
    .wstrb(dmem_wstrb)
  );

  // SRAM read is combinational, so loads format right here
  rv_load_fmt u_load_fmt (
    .rdata(dmem_rdata),
    .byte_off(mem_in.alu_result[1:0]),
    .funct3(mem_in.funct3),
    .data(load_data)
  );

  // Forwarding value for younger instructions
  always_comb begin
    case (mem_in.res_sel)
      res_mem: result_mem = load_data;
      res_pc4: result_mem = mem_in.pc_plus4;
      res_tgt: result_mem = mem_in.jb_target;
      default: result_mem = mem_in.alu_result;
    endcase
  end

  rv_redirect_check u_redirect_check (
    .bp_in(bp_in),
    .pc_plus4(mem_in.pc_plus4),
    .jb_target(mem_in.jb_target),
    .instr(mem_in.instr),
    .redirect(redirect),
    .ras_upd(ras_upd)
  );

  // WB payload, no register write behind a trap
  assign wb_d.reg_write = mem_in.reg_write && !trap_any;
  assign wb_d.res_sel = mem_in.res_sel;
  assign wb_d.rd = mem_in.rd;
  assign wb_d.funct3 = mem_in.funct3;
  assign wb_d.alu_result = mem_in.alu_result;
  assign wb_d.pc_plus4 = mem_in.pc_plus4;
  assign wb_d.jb_target = mem_in.jb_target;
  assign wb_d.load_data = load_data;

  rv_pipe_reg #(
    .payload_t(wb_out_t),
    .rst_val(wb_rst)
  ) u_wb_reg (
    .clk(clk),
    .rst_n(rst_n),
    .stall(stall),
    .d(wb_d),
    .q(wb_out)
  );

  // Valid and trap carry the multi-cycle rule
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_wb <= 1'b0;
      trap_wb <= 1'b0;
      trap_code_wb <= trap_none;
    end else if (!stall) begin
      valid_wb <= mem_in.valid;
      trap_wb <= trap_any;
      trap_code_wb <= trap_code_mem;
    end else if (op_active) begin
      // Execute busy, so retire nothing but keep the trap current
      valid_wb <= 1'b0;
      trap_wb <= trap_any;
      trap_code_wb <= trap_code_mem;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_store_fmt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_store_fmt import rv_mem_pkg::*; (
  input logic [`RV_XLEN-1:0] data,
  input logic [1:0] byte_off,
  input logic [2:0] funct3,
  input logic mem_write,
  output logic [`RV_XLEN-1:0] wdata,
  output logic [3:0] wstrb
);

  logic [3:0] lane_mask;

  // Replicate the stored value so every lane carries it
  // The strobes then decide which lanes land in memory
  always_comb begin
    case (funct3)
      f3_byte: begin
        wdata = {4{data[7:0]}};
        lane_mask = 4'b0001 << byte_off;
      end
      f3_half: begin
        wdata = {2{data[15:0]}};
        // Upper or lower halfword by address bit 1
        lane_mask = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = data;
        lane_mask = 4'b1111;
      end
    endcase
  end

  // No strobes without a store
  assign wstrb = mem_write ? lane_mask : 4'b0000;

endmodule

`default_nettype wire

// ==== verification/rv_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_checker import rv_mem_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic drv_valid,
  input int test_idx,
  input mem_in_t mem_in,
  input logic stall,
  input logic op_active,
  input logic exp_trap,
  input logic exp_misp,
  input logic exp_jmisp,
  input logic [`RV_XLEN-1:0] exp_target,
  input logic exp_push,
  input logic exp_pop,
  input logic [`RV_XLEN-1:0] result_mem,
  input redirect_t redirect,
  input ras_upd_t ras_upd,
  input wb_out_t wb_out,
  input logic valid_wb,
  input logic trap_wb,
  input trap_code_t trap_code_wb,
  output int test_count,
  output int error_count
);

  // Shadow of the data SRAM
  logic [31:0] shadow [`RV_DMEM_WORDS];

  // Expected WB state after the next edge
  logic m_valid;
  logic m_trap;
  trap_code_t m_code;
  logic m_reg_write;
  res_sel_t m_res_sel;
  logic [4:0] m_rd;
  logic [2:0] m_f3;
  logic [31:0] m_load;
  logic [31:0] m_alu;
  logic [31:0] m_pc4;
  logic [31:0] m_tgt;
  logic pending;
  int pend_idx;
  int err_base;
  logic reset_checked;

  initial begin
    test_count = 0;
    error_count = 0;
    reset_checked = 1'b0;
    pending = 1'b0;
  end

  // Lane pick and extension as RV32 loads define them
  function automatic logic [31:0] extend_lane(input logic [31:0] w, input logic [1:0] off,
                                              input logic [2:0] f3);
    logic [7:0] b;
    logic [15:0] h;
    b = w >> (off * 8);
    h = off[1] ? w[31:16] : w[15:0];
    case (f3)
      f3_byte: return {{24{b[7]}}, b};
      f3_byte_u: return {24'h0, b};
      f3_half: return {{16{h[15]}}, h};
      f3_half_u: return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic write_shadow(input logic [31:0] addr, input logic [31:0] d,
                              input logic [2:0] f3);
    logic [7:0] idx;
    idx = addr[9:2];
    case (f3)
      f3_byte: shadow[idx][addr[1:0]*8 +: 8] = d[7:0];
      f3_half: shadow[idx][addr[1]*16 +: 16] = d[15:0];
      default: shadow[idx] = d;
    endcase
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      error_count++;
      $display("** Error @%0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  always @(negedge clk) begin
    logic [31:0] ld;
    logic [31:0] exp_res;
    if (!rst_n) begin
      m_valid = 1'b0;
      m_trap = 1'b0;
      m_code = trap_none;
      m_reg_write = 1'b0;
      m_res_sel = res_alu;
      m_rd = '0;
      m_f3 = '0;
      m_load = '0;
      m_alu = '0;
      m_pc4 = '0;
      m_tgt = '0;
      pending = 1'b0;
    end else begin
      if (!reset_checked) begin
        err_base = error_count;
        compare("valid_wb", 32'(1'b0), 32'(valid_wb));
        compare("wb_out.reg_write", 32'(1'b0), 32'(wb_out.reg_write));
        compare("trap_wb", 32'(1'b0), 32'(trap_wb));
        $display("test reset %s", (error_count == err_base) ? "ok" : "FAILED");
        test_count++;
        reset_checked = 1'b1;
      end
      // Registered outputs of the row applied one edge ago
      if (pending) begin
        compare("valid_wb", 32'(m_valid), 32'(valid_wb));
        compare("trap_wb", 32'(m_trap), 32'(trap_wb));
        compare("trap_code_wb", 32'(m_code), 32'(trap_code_wb));
        compare("wb_out.reg_write", 32'(m_reg_write), 32'(wb_out.reg_write));
        compare("wb_out.res_sel", 32'(m_res_sel), 32'(wb_out.res_sel));
        compare("wb_out.rd", 32'(m_rd), 32'(wb_out.rd));
        compare("wb_out.funct3", 32'(m_f3), 32'(wb_out.funct3));
        compare("wb_out.load_data", m_load, wb_out.load_data);
        compare("wb_out.alu_result", m_alu, wb_out.alu_result);
        compare("wb_out.pc_plus4", m_pc4, wb_out.pc_plus4);
        compare("wb_out.jb_target", m_tgt, wb_out.jb_target);
        $display("test %0d %s", pend_idx, (error_count == err_base) ? "ok" : "FAILED");
        test_count++;
        pending = 1'b0;
      end
      if (drv_valid) begin
        err_base = error_count;
        // Port reads zero when the load is suppressed
        if (mem_in.mem_read && !exp_trap) begin
          ld = extend_lane(shadow[mem_in.alu_result[9:2]], mem_in.alu_result[1:0],
                           mem_in.funct3);
        end else begin
          ld = '0;
        end
        case (mem_in.res_sel)
          res_mem: exp_res = ld;
          res_pc4: exp_res = mem_in.pc_plus4;
          res_tgt: exp_res = mem_in.jb_target;
          default: exp_res = mem_in.alu_result;
        endcase
        compare("result_mem", exp_res, result_mem);
        compare("redirect.mispredicted", 32'(exp_misp), 32'(redirect.mispredicted));
        compare("redirect.jalr_mispredicted", 32'(exp_jmisp),
                32'(redirect.jalr_mispredicted));
        compare("redirect.target", exp_target, redirect.target);
        compare("ras_upd.push", 32'(exp_push), 32'(ras_upd.push));
        compare("ras_upd.pop", 32'(exp_pop), 32'(ras_upd.pop));
        if (exp_push) begin
          compare("ras_upd.push_addr", mem_in.pc_plus4, ras_upd.push_addr);
        end
        // Next WB state
        if (!stall) begin
          m_valid = mem_in.valid;
          m_reg_write = mem_in.reg_write && !exp_trap;
          m_res_sel = mem_in.res_sel;
          m_rd = mem_in.rd;
          m_f3 = mem_in.funct3;
          m_load = ld;
          m_alu = mem_in.alu_result;
          m_pc4 = mem_in.pc_plus4;
          m_tgt = mem_in.jb_target;
        end else if (op_active) begin
          m_valid = 1'b0;
        end
        if (!stall || op_active) begin
          m_trap = exp_trap;
          m_code = exp_trap ? trap_ldst_misalign : trap_none;
        end
        // SRAM writes land at the edge regardless of stall
        if (mem_in.mem_write && !exp_trap) begin
          write_shadow(mem_in.alu_result, mem_in.rs2_data, mem_in.funct3);
        end
        pend_idx = test_idx;
        pending = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rv_mem_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_props import rv_mem_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic stall,
  input logic op_active,
  input mem_in_t mem_in,
  input logic dmem_ren,
  input logic dmem_we,
  input wb_out_t wb_out,
  input logic valid_wb,
  input logic trap_wb,
  input trap_code_t trap_code_wb
);

  int fail_count;
  logic half_odd;
  logic word_off;

  initial fail_count = 0;

  // Alignment faults from access size and low address bits
  assign half_odd = ((mem_in.funct3 == f3_half) || (mem_in.funct3 == f3_half_u)) &&
                    mem_in.alu_result[0];
  assign word_off = (mem_in.funct3 == f3_word) && (mem_in.alu_result[1:0] != 2'b00);

  // Reset clears valid on the following edge
  a_reset_valid: assert property (@(posedge clk) !rst_n |=> !valid_wb)
    else begin
      $error("valid_wb set after reset");
      fail_count++;
    end

  // Execute trap or bad alignment keeps the SRAM port quiet
  a_trap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_in.trap || half_odd || word_off) |-> (!dmem_ren && !dmem_we))
    else begin
      $error("memory enable high while a trap is present");
      fail_count++;
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && !op_active) |=> ($stable(wb_out) && $stable(valid_wb) &&
                               $stable(trap_wb) && $stable(trap_code_wb)))
    else begin
      $error("WB outputs changed during a plain stall");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/rv_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_tb import rv_mem_pkg::*; ();

  // Row kinds of the stimulus table
  localparam logic [2:0] k_alu = 3'd0;
  localparam logic [2:0] k_st = 3'd1;
  localparam logic [2:0] k_ld = 3'd2;
  localparam logic [2:0] k_pc4 = 3'd3;
  localparam logic [2:0] k_tgt = 3'd4;
  localparam logic [2:0] k_jal = 3'd5;
  localparam logic [2:0] k_ctl = 3'd6;

  typedef struct packed {
    logic [2:0] kind;
    logic [2:0] f3;
    logic [9:0] addr;
    logic [4:0] rd;
    logic is_branch;
    logic is_jalr;
    logic taken;
    logic pred_taken;
    logic pred_ok;
    logic stall;
    logic op_active;
    logic exp_trap;
    logic exp_misp;
    logic exp_jmisp;
    logic exp_tgt_pc4;
    logic exp_push;
    logic exp_pop;
  } entry_t;

  logic clk;
  logic rst_n;
  mem_in_t mem_in;
  bp_in_t bp_in;
  logic stall;
  logic op_active;
  logic [`RV_XLEN-1:0] result_mem;
  redirect_t redirect;
  ras_upd_t ras_upd;
  wb_out_t wb_out;
  logic valid_wb;
  logic trap_wb;
  trap_code_t trap_code_wb;

  // Expected columns of the row now applied
  logic drv_valid;
  int test_idx;
  logic exp_trap;
  logic exp_misp;
  logic exp_jmisp;
  logic [`RV_XLEN-1:0] exp_target;
  logic exp_push;
  logic exp_pop;
  int test_count;
  int error_count;

  entry_t tbl[$];
  logic tbl_ready;
  logic [31:0] rnd;

  rv_mem_subsys rv_mem_subsys_i (
    .clk(clk),
    .rst_n(rst_n),
    .mem_in(mem_in),
    .bp_in(bp_in),
    .stall(stall),
    .op_active(op_active),
    .result_mem(result_mem),
    .redirect(redirect),
    .ras_upd(ras_upd),
    .wb_out(wb_out),
    .valid_wb(valid_wb),
    .trap_wb(trap_wb),
    .trap_code_wb(trap_code_wb)
  );

  rv_mem_checker u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .drv_valid(drv_valid),
    .test_idx(test_idx),
    .mem_in(mem_in),
    .stall(stall),
    .op_active(op_active),
    .exp_trap(exp_trap),
    .exp_misp(exp_misp),
    .exp_jmisp(exp_jmisp),
    .exp_target(exp_target),
    .exp_push(exp_push),
    .exp_pop(exp_pop),
    .result_mem(result_mem),
    .redirect(redirect),
    .ras_upd(ras_upd),
    .wb_out(wb_out),
    .valid_wb(valid_wb),
    .trap_wb(trap_wb),
    .trap_code_wb(trap_code_wb),
    .test_count(test_count),
    .error_count(error_count)
  );

  bind rv_stage_mem rv_mem_props u_props (
    .clk(clk),
    .rst_n(rst_n),
    .stall(stall),
    .op_active(op_active),
    .mem_in(mem_in),
    .dmem_ren(dmem_ren),
    .dmem_we(dmem_we),
    .wb_out(wb_out),
    .valid_wb(valid_wb),
    .trap_wb(trap_wb),
    .trap_code_wb(trap_code_wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_mem(input logic [2:0] kind, input logic [2:0] f3,
                         input logic [9:0] addr, input logic trap);
    entry_t e;
    e = '0;
    e.kind = kind;
    e.f3 = f3;
    e.addr = addr;
    e.rd = 5'd5;
    e.exp_trap = trap;
    tbl.push_back(e);
  endtask

  task automatic add_ctl(input logic [2:0] kind, input logic [4:0] rd, input logic br,
                         input logic jalr, input logic tk, input logic pt, input logic pok,
                         input logic misp, input logic jmisp, input logic tpc4,
                         input logic push, input logic pop);
    entry_t e;
    e = '0;
    e.kind = kind;
    e.rd = rd;
    e.is_branch = br;
    e.is_jalr = jalr;
    e.taken = tk;
    e.pred_taken = pt;
    e.pred_ok = pok;
    e.exp_misp = misp;
    e.exp_jmisp = jmisp;
    e.exp_tgt_pc4 = tpc4;
    e.exp_push = push;
    e.exp_pop = pop;
    tbl.push_back(e);
  endtask

  task automatic add_stall(input logic st, input logic oa, input logic [2:0] f3,
                           input logic [9:0] addr, input logic trap);
    entry_t e;
    e = '0;
    e.kind = k_ld;
    e.f3 = f3;
    e.addr = addr;
    e.rd = 5'd7;
    e.stall = st;
    e.op_active = oa;
    e.exp_trap = trap;
    tbl.push_back(e);
  endtask

  // Turn one table row into execute-stage signals
  task automatic drive_entry(input entry_t e, input int i);
    logic [31:0] jb;
    logic [31:0] pc4;
    logic is_mem;
    rnd = xorshift32(rnd);
    jb = 32'h2000 + 16 * i;
    pc4 = 32'h1000 + 4 * i;
    is_mem = (e.kind == k_st) || (e.kind == k_ld);
    mem_in = '0;
    mem_in.valid = 1'b1;
    mem_in.reg_write = (e.kind != k_st);
    mem_in.mem_read = (e.kind == k_ld);
    mem_in.mem_write = (e.kind == k_st);
    case (e.kind)
      k_ld: mem_in.res_sel = res_mem;
      k_pc4, k_jal: mem_in.res_sel = res_pc4;
      k_tgt: mem_in.res_sel = res_tgt;
      default: mem_in.res_sel = res_alu;
    endcase
    mem_in.funct3 = e.f3;
    mem_in.rd = e.rd;
    if (e.kind == k_jal) begin
      mem_in.instr = {20'h0, e.rd, op_jal};
    end else if (e.is_jalr) begin
      mem_in.instr = {20'h0, e.rd, 7'b1100111};
    end else if (e.is_branch) begin
      mem_in.instr = {20'h0, 5'd0, 7'b1100011};
    end else begin
      mem_in.instr = op_nop;
    end
    mem_in.alu_result = is_mem ? {22'h0, e.addr} : xorshift32(rnd ^ 32'h55);
    mem_in.rs2_data = rnd;
    mem_in.pc_plus4 = pc4;
    mem_in.jb_target = jb;
    mem_in.trap_code = trap_none;
    bp_in.is_branch = e.is_branch;
    bp_in.is_jalr = e.is_jalr;
    bp_in.branch_taken = e.taken;
    bp_in.pred_taken = e.pred_taken;
    bp_in.pred_target = e.pred_ok ? jb : jb + 4;
    stall = e.stall;
    op_active = e.op_active;
    exp_trap = e.exp_trap;
    exp_misp = e.exp_misp;
    exp_jmisp = e.exp_jmisp;
    exp_target = e.exp_tgt_pc4 ? pc4 : jb;
    exp_push = e.exp_push;
    exp_pop = e.exp_pop;
    test_idx = i;
    drv_valid = 1'b1;
  endtask

  task automatic drive_idle();
    mem_in = '0;
    mem_in.instr = op_nop;
    bp_in = '0;
    stall = 1'b0;
    op_active = 1'b0;
    drv_valid = 1'b0;
    exp_trap = 1'b0;
    exp_misp = 1'b0;
    exp_jmisp = 1'b0;
    exp_target = '0;
    exp_push = 1'b0;
    exp_pop = 1'b0;
  endtask

  // Stimulus table
  task automatic build_table();
    // Word fills, then byte and halfword patches
    add_mem(k_st, f3_word, 10'h010, 1'b0);
    add_mem(k_st, f3_word, 10'h014, 1'b0);
    add_mem(k_st, f3_byte, 10'h011, 1'b0);
    add_mem(k_st, f3_half, 10'h016, 1'b0);
    add_mem(k_ld, f3_byte, 10'h010, 1'b0);
    add_mem(k_ld, f3_byte, 10'h011, 1'b0);
    add_mem(k_ld, f3_byte, 10'h012, 1'b0);
    add_mem(k_ld, f3_byte_u, 10'h013, 1'b0);
    add_mem(k_ld, f3_byte_u, 10'h010, 1'b0);
    add_mem(k_ld, f3_byte_u, 10'h011, 1'b0);
    add_mem(k_ld, f3_byte_u, 10'h012, 1'b0);
    add_mem(k_ld, f3_byte, 10'h013, 1'b0);
    add_mem(k_ld, f3_half, 10'h014, 1'b0);
    add_mem(k_ld, f3_half_u, 10'h014, 1'b0);
    add_mem(k_ld, f3_half, 10'h016, 1'b0);
    add_mem(k_ld, f3_half_u, 10'h016, 1'b0);
    add_mem(k_ld, f3_word, 10'h010, 1'b0);
    add_mem(k_ld, f3_word, 10'h014, 1'b0);
    // Misaligned accesses trap and leave memory alone
    add_mem(k_st, f3_word, 10'h011, 1'b1);
    add_mem(k_st, f3_half, 10'h015, 1'b1);
    add_mem(k_ld, f3_half_u, 10'h013, 1'b1);
    add_mem(k_ld, f3_word, 10'h010, 1'b0);
    add_mem(k_ld, f3_word, 10'h014, 1'b0);
    // Forwarding selectors
    add_ctl(k_alu, 5'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_ctl(k_pc4, 5'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_ctl(k_tgt, 5'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // Branch and jump cases
    add_ctl(k_ctl, 5'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    add_ctl(k_ctl, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    add_ctl(k_ctl, 5'd1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    add_ctl(k_jal, 5'd1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    add_ctl(k_ctl, 5'd0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    // Load, plain stall, stall during a busy execute, then resume
    add_mem(k_ld, f3_word, 10'h014, 1'b0);
    add_stall(1'b1, 1'b0, f3_byte, 10'h012, 1'b0);
    add_stall(1'b1, 1'b0, f3_word, 10'h022, 1'b1);
    add_stall(1'b1, 1'b1, f3_word, 10'h022, 1'b1);
    add_stall(1'b0, 1'b0, f3_half, 10'h016, 1'b0);
  endtask

  initial begin
    int total_errors;
    rst_n = 1'b0;
    rnd = 32'h9619;
    tbl_ready = 1'b0;
    test_idx = 0;
    drive_idle();
    build_table();
    tbl_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    foreach (tbl[i]) begin
      @(posedge clk);
      #1 drive_entry(tbl[i], i);
    end
    @(posedge clk);
    #1 drive_idle();
    repeat (2) @(negedge clk);
    // Checker mismatches plus failed bound assertions
    total_errors = error_count + rv_mem_subsys_i.u_stage_mem.u_props.fail_count;
    $display("tests %0d errors %0d", test_count, total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog scaled by the table length
  initial begin
    int wd_ns;
    wait (tbl_ready);
    wd_ns = (tbl.size() + 14) * 8 + 200;
    #(wd_ns);
    $display("Timeout: the run did not finish within %0d ns", wd_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
